// ==== tb.f ====
common/dsp_const_pkg.sv
common/dsp_cfg_pkg.sv
verilog/lane_delay.sv
ffe_slicer/ffe_slicer.sv
channel_filter/channel_filter.sv
error_detector/error_detector.sv
verilog/datapath_core.sv
bench/dsp_model_pkg.sv
bench/tb_datapath_core.sv

// ==== bench/tb_datapath_core.sv ====
module tb_datapath_core
    import dsp_const_pkg::*, dsp_cfg_pkg::*, dsp_model_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int latency      = 4;
    localparam int reset_cycles = 8;
    localparam int drain_limit  = 16;
    localparam int out_w        = $bits(dsp_out_t);

    logic      clk;
    logic      rst_i;
    adc_word_t adc_i;
    dsp_cfg_t  cfg_i;
    dsp_out_t  dsp_out_o;

    int           seed;
    model_state_t st;
    dsp_out_t     exp_q [$];
    bit           chk_q [$];
    string        cur_test;
    int           test_errors;
    int           total_errors;
    int           tests_run;
    int           tests_failed;
    int           flags_seen;

    datapath_core uut (
        .clk       (clk),
        .rst_i     (rst_i),
        .adc_i     (adc_i),
        .cfg_i     (cfg_i),
        .dsp_out_o (dsp_out_o)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string what, input logic [out_w-1:0] exp_v,
                             input logic [out_w-1:0] act_v);
        if (exp_v !== act_v) begin
            test_errors++;
            total_errors++;
            $display("Error: %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
        end
    endtask

    function automatic code_arr_t random_word();
        code_arr_t w;
        int        r;

        for (int i = 0; i < num_lanes; i++) begin
            r    = $random(seed);
            w[i] = r[code_bits-1:0];
        end
        return w;
    endfunction

    function automatic dsp_cfg_t random_cfg();
        dsp_cfg_t c;
        int       r;

        c = '0;
        for (int k = 0; k < ffe_taps; k++) begin
            r = $random(seed);
            c.weights[k] = r[weight_bits-1:0];
        end
        r = $random(seed);
        c.ffe_shift = r[2:0];
        r = $random(seed);
        c.thresh = est_t'(r % 48);
        for (int k = 0; k < chan_taps; k++) begin
            r = $random(seed);
            c.taps[k] = r[tap_bits-1:0];
        end
        return c;
    endfunction

    // w0 = 1, no shift, threshold at zero
    function automatic dsp_cfg_t passthrough_cfg();
        dsp_cfg_t c;

        c            = '0;
        c.weights[0] = 8'sd1;
        c.taps[0]    = 8'sd40;
        c.taps[1]    = 8'sd12;
        c.taps[2]    = -8'sd6;
        return c;
    endfunction

    function automatic bit checks_pending();
        foreach (chk_q[i]) begin
            if (chk_q[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic reset_dut();
        rst_i = 1'b1;
        st    = '0;
        exp_q.delete();
        chk_q.delete();
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            #1;
        end
        check_val("reset output", '0, dsp_out_o);
        rst_i = 1'b0;
    endtask

    // Compare the word due now, model the new one, then drive it for one cycle
    task automatic send_word(input code_arr_t w, input bit chk);
        dsp_out_t             exp_cur;
        dsp_out_t             tmp;
        logic [num_lanes-1:0] pflags;
        bit                   front_chk;

        if (exp_q.size() == latency) begin
            tmp       = exp_q.pop_front();
            front_chk = chk_q.pop_front();
            if (front_chk) begin
                check_val("est_bits", tmp.est_bits, dsp_out_o.est_bits);
                check_val("sliced", tmp.sliced, dsp_out_o.sliced);
                check_val("est_codes", tmp.est_codes, dsp_out_o.est_codes);
                check_val("errors", tmp.errors, dsp_out_o.errors);
                check_val("flags", tmp.flags, dsp_out_o.flags);
                flags_seen += $countones(dsp_out_o.flags);
            end
        end
        word_step(cfg_i, w, st, exp_cur, pflags);
        if (exp_q.size() > 0) begin
            tmp       = exp_q[exp_q.size()-1];
            tmp.flags = pflags;
            exp_q[exp_q.size()-1] = tmp;
        end
        exp_q.push_back(exp_cur);
        chk_q.push_back(chk);
        adc_i.codes = w;
        @(posedge clk);
        #1;
    endtask

    // Keep the stream going until every checked word has come out
    task automatic drain_stream();
        int waited;

        waited = 0;
        while (checks_pending() && waited < drain_limit) begin
            send_word(random_word(), 1'b0);
            waited++;
        end
        if (checks_pending()) begin
            test_errors++;
            total_errors++;
            $display("Test %s timed out while waiting for the last outputs", cur_test);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %s passed", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", cur_test, test_errors);
        end
    endtask

    initial begin
        dsp_cfg_t cfg_work;
        int       r;

        clk          = 1'b0;
        rst_i        = 1'b1;
        adc_i        = '0;
        cfg_i        = '0;
        seed         = 32'h7efa;
        st           = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        flags_seen   = 0;

        start_test("reset");
        cfg_i = passthrough_cfg();
        reset_dut();
        finish_test();

        start_test("pass_through_ffe");
        reset_dut();
        for (int i = 0; i < 100; i++) begin
            send_word(random_word(), 1'b1);
        end
        drain_stream();
        finish_test();

        start_test("random_ffe");
        cfg_i = random_cfg();
        reset_dut();
        for (int i = 0; i < 200; i++) begin
            send_word(random_word(), 1'b1);
        end
        drain_stream();
        finish_test();

        start_test("channel_filter_error");
        cfg_i = random_cfg();
        reset_dut();
        for (int i = 0; i < 150; i++) begin
            send_word(random_word(), 1'b1);
        end
        drain_stream();
        finish_test();

        // Strong main cursor against full-range codes
        start_test("sliding_detector");
        cfg_work = passthrough_cfg();
        r = $random(seed);
        cfg_work.taps[0] = tap_t'(90 + r % 20);
        r = $random(seed);
        cfg_work.taps[1] = tap_t'(r % 16);
        r = $random(seed);
        cfg_work.taps[2] = tap_t'(r % 8);
        cfg_i = cfg_work;
        reset_dut();
        flags_seen = 0;
        for (int i = 0; i < 200; i++) begin
            send_word(random_word(), 1'b1);
        end
        drain_stream();
        if (flags_seen == 0) begin
            test_errors++;
            total_errors++;
            $display("Test %s never saw a detector flag set", cur_test);
        end
        finish_test();

        // Words in flight under mixed settings are skipped
        start_test("config_change");
        cfg_i = random_cfg();
        foreach (chk_q[i]) begin
            chk_q[i] = 1'b0;
        end
        for (int i = 0; i < latency; i++) begin
            send_word(random_word(), 1'b0);
        end
        for (int i = 0; i < 100; i++) begin
            send_word(random_word(), 1'b1);
        end
        drain_stream();
        finish_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_datapath_core

// ==== bench/dsp_model_pkg.sv ====
package dsp_model_pkg;

    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;

    // Histories carried from one word to the next
    typedef struct packed {
        code_arr_t            prev_codes;
        logic [num_lanes-1:0] prev_bits;
        err_arr_t             prev_err;
    } model_state_t;

    // One word through FFE, slicer, channel rebuild and error.
    // The flags of the word before come out too, now that this word's error is known
    function automatic void word_step(
        input  dsp_cfg_t             cfg,
        input  code_arr_t            codes,
        inout  model_state_t         st,
        output dsp_out_t             cur,
        output logic [num_lanes-1:0] prev_flags
    );
        int   sum;
        int   acc;
        int   idx;
        int   code_v;
        int   diff;
        int   s;
        int   e_cur;
        int   e_next;
        int   d_cur;
        int   d_next;
        logic b;

        cur        = '0;
        prev_flags = '0;

        for (int j = 0; j < num_lanes; j++) begin
            sum = 0;
            for (int k = 0; k < ffe_taps; k++) begin
                idx = j - k;
                if (idx >= 0) begin
                    code_v = int'($signed(codes[idx]));
                end else begin
                    code_v = int'($signed(st.prev_codes[idx+num_lanes]));
                end
                sum = sum + int'($signed(cfg.weights[k])) * code_v;
            end
            sum = sum >>> cfg.ffe_shift;
            cur.est_bits[j] = sum[est_bits_w-1:0];
            cur.sliced[j]   = ($signed(cur.est_bits[j]) >= $signed(cfg.thresh));
        end

        for (int j = 0; j < num_lanes; j++) begin
            acc = 0;
            for (int k = 0; k < chan_taps; k++) begin
                idx = j - k;
                if (idx >= 0) begin
                    b = cur.sliced[idx];
                end else begin
                    b = st.prev_bits[idx+num_lanes];
                end
                acc = acc + (b ? 1 : -1) * int'($signed(cfg.taps[k]));
            end
            diff = acc - int'($signed(codes[j]));
            cur.est_codes[j] = acc[est_code_bits-1:0];
            cur.errors[j]    = diff[err_bits-1:0];
        end

        // Flip test on the previous word, lane 3 looks at lane 0 of this one
        for (int j = 0; j < num_lanes; j++) begin
            e_cur = int'($signed(st.prev_err[j]));
            if (j < num_lanes - 1) begin
                e_next = int'($signed(st.prev_err[j+1]));
            end else begin
                e_next = int'($signed(cur.errors[0]));
            end
            s      = st.prev_bits[j] ? 1 : -1;
            d_cur  = e_cur - 2 * s * int'($signed(cfg.taps[0]));
            d_next = e_next - 2 * s * int'($signed(cfg.taps[1]));
            prev_flags[j] = (d_cur * d_cur + d_next * d_next) < (e_cur * e_cur + e_next * e_next);
        end

        st.prev_codes = codes;
        st.prev_bits  = cur.sliced;
        st.prev_err   = cur.errors;
    endfunction

endpackage : dsp_model_pkg

// ==== verilog/datapath_core.sv ====
module datapath_core
    import dsp_const_pkg::*, dsp_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  adc_word_t adc_i,
    input  dsp_cfg_t  cfg_i,
    output dsp_out_t  dsp_out_o
);

    localparam int adc_w   = $bits(adc_word_t);
    localparam int est_w   = $bits(est_arr_t);
    localparam int ecode_w = $bits(ecode_arr_t);

    // Stage outputs are named by the edge that loads them
    localparam int adc_to_err_depth   = 2;
    localparam int bits_to_err_depth  = 2;
    localparam int bits_to_out_depth  = 1;
    localparam int est_to_out_depth   = 3;
    localparam int ecode_to_out_depth = 2;

    est_arr_t             est_s1;
    logic [num_lanes-1:0] sliced_s1;
    ecode_arr_t           est_code_s2;
    adc_word_t            adc_s2;
    logic [num_lanes-1:0] sliced_s3;
    logic [num_lanes-1:0] sliced_s4;
    est_arr_t             est_s4;
    ecode_arr_t           est_code_s4;
    err_arr_t             err_s4;
    logic [num_lanes-1:0] flag_s4;

    ffe_slicer u_ffe_slicer (
        .clk      (clk),
        .rst_i    (rst_i),
        .adc_i    (adc_i),
        .cfg_i    (cfg_i),
        .est_o    (est_s1),
        .sliced_o (sliced_s1)
    );

    channel_filter u_channel_filter (
        .clk        (clk),
        .rst_i      (rst_i),
        .sliced_i   (sliced_s1),
        .cfg_i      (cfg_i),
        .est_code_o (est_code_s2)
    );

    error_detector u_error_detector (
        .clk        (clk),
        .rst_i      (rst_i),
        .est_code_i (est_code_s2),
        .adc_i      (adc_s2),
        .sliced_i   (sliced_s3),
        .cfg_i      (cfg_i),
        .err_o      (err_s4),
        .flag_o     (flag_s4)
    );

    // Raw codes meet the rebuilt codes
    lane_delay #(.width(adc_w), .depth(adc_to_err_depth)) u_adc_dly (
        .clk (clk), .rst_i (rst_i), .d_i (adc_i), .q_o (adc_s2)
    );

    // Decisions meet the held error word in the detector
    lane_delay #(.width(num_lanes), .depth(bits_to_err_depth)) u_bits_err_dly (
        .clk (clk), .rst_i (rst_i), .d_i (sliced_s1), .q_o (sliced_s3)
    );

    lane_delay #(.width(num_lanes), .depth(bits_to_out_depth)) u_bits_out_dly (
        .clk (clk), .rst_i (rst_i), .d_i (sliced_s3), .q_o (sliced_s4)
    );

    lane_delay #(.width(est_w), .depth(est_to_out_depth)) u_est_dly (
        .clk (clk), .rst_i (rst_i), .d_i (est_s1), .q_o (est_s4)
    );

    lane_delay #(.width(ecode_w), .depth(ecode_to_out_depth)) u_ecode_dly (
        .clk (clk), .rst_i (rst_i), .d_i (est_code_s2), .q_o (est_code_s4)
    );

    assign dsp_out_o = '{
        est_bits:  est_s4,
        sliced:    sliced_s4,
        est_codes: est_code_s4,
        errors:    err_s4,
        flags:     flag_s4
    };

endmodule : datapath_core

// ==== error_detector/error_detector.sv ====
module error_detector
    import dsp_const_pkg::*, dsp_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  ecode_arr_t           est_code_i,
    input  adc_word_t            adc_i,
    input  logic [num_lanes-1:0] sliced_i,
    input  dsp_cfg_t             cfg_i,
    output err_arr_t             err_o,
    output logic [num_lanes-1:0] flag_o
);

    // Headroom for err minus twice a tap, and for the sum of two squares
    localparam int diff_bits = err_bits + 2;
    localparam int cost_bits = 2 * diff_bits + 1;

    err_arr_t             err_c;
    err_arr_t             err_q;
    err_t                 ext_err [num_lanes+1];
    logic [num_lanes-1:0] flag_c;

    always_comb begin
        for (int j = 0; j < num_lanes; j++) begin
            err_c[j] = $signed(est_code_i[j]) - $signed(adc_i.codes[j]);
        end
    end

    // Held word plus lane 0 of the word right behind it
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            ext_err[i] = err_q[i];
        end
        ext_err[num_lanes] = err_c[0];
    end

    // Would flipping bit j lower the error energy over lanes j and j+1
    always_comb begin
        logic signed [diff_bits-1:0] two_h0;
        logic signed [diff_bits-1:0] two_h1;
        logic signed [diff_bits-1:0] e_cur;
        logic signed [diff_bits-1:0] e_next;
        logic signed [diff_bits-1:0] d_cur;
        logic signed [diff_bits-1:0] d_next;
        logic signed [cost_bits-1:0] cost_keep;
        logic signed [cost_bits-1:0] cost_flip;

        two_h0 = $signed(cfg_i.taps[0]);
        two_h0 = two_h0 <<< 1;
        two_h1 = $signed(cfg_i.taps[1]);
        two_h1 = two_h1 <<< 1;
        e_cur     = '0;
        e_next    = '0;
        d_cur     = '0;
        d_next    = '0;
        cost_keep = '0;
        cost_flip = '0;
        for (int j = 0; j < num_lanes; j++) begin
            e_cur  = $signed(ext_err[j]);
            e_next = $signed(ext_err[j+1]);
            if (sliced_i[j]) begin
                d_cur  = e_cur - two_h0;
                d_next = e_next - two_h1;
            end else begin
                d_cur  = e_cur + two_h0;
                d_next = e_next + two_h1;
            end
            cost_keep = e_cur * e_cur + e_next * e_next;
            cost_flip = d_cur * d_cur + d_next * d_next;
            flag_c[j] = (cost_flip < cost_keep);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            err_q  <= '0;
            err_o  <= '0;
            flag_o <= '0;
        end else begin
            err_q  <= err_c;
            err_o  <= err_q;
            flag_o <= flag_c;
        end
    end

    // No channel memory in the window means no flip can help
    a_no_flag_flat : assert property (
        @(posedge clk) disable iff (rst_i)
        (cfg_i.taps[0] == '0 && cfg_i.taps[1] == '0) |=> (flag_o == '0)
    ) else $error("error_detector: flag set with h0 and h1 at zero");

endmodule : error_detector

// ==== channel_filter/channel_filter.sv ====
module channel_filter
    import dsp_const_pkg::*, dsp_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [num_lanes-1:0] sliced_i,
    input  dsp_cfg_t             cfg_i,
    output ecode_arr_t           est_code_o
);

    logic [num_lanes-1:0]   prev_bits;
    logic [2*num_lanes-1:0] ext_bits;
    ecode_arr_t             est_code_c;
    ecode_t                 tap_abs_sum;

    if (chan_taps > num_lanes + 1) begin : g_taps_chk
        $error("channel_filter: chan_taps exceeds one word of history");
    end

    // Older decisions in the low half
    assign ext_bits = {sliced_i, prev_bits};

    // Each decision counts as +h or -h
    always_comb begin
        ecode_t acc;
        ecode_t tap_ext;

        acc     = '0;
        tap_ext = '0;
        for (int j = 0; j < num_lanes; j++) begin
            acc = '0;
            for (int k = 0; k < chan_taps; k++) begin
                tap_ext = $signed(cfg_i.taps[k]);
                if (ext_bits[j+num_lanes-k]) begin
                    acc = acc + tap_ext;
                end else begin
                    acc = acc - tap_ext;
                end
            end
            est_code_c[j] = acc;
        end
    end

    // Largest magnitude any rebuilt code can reach
    always_comb begin
        ecode_t tap_mag;

        tap_mag     = '0;
        tap_abs_sum = '0;
        for (int k = 0; k < chan_taps; k++) begin
            tap_mag     = $signed(cfg_i.taps[k]);
            tap_abs_sum = tap_abs_sum + ((tap_mag < 0) ? -tap_mag : tap_mag);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            prev_bits  <= '0;
            est_code_o <= '0;
        end else begin
            prev_bits  <= sliced_i;
            est_code_o <= est_code_c;
        end
    end

    for (genvar j = 0; j < num_lanes; j++) begin : g_range_chk
        a_code_range : assert property (
            @(posedge clk) disable iff (rst_i)
            $stable(cfg_i) |-> ($signed(est_code_o[j]) <= tap_abs_sum
                                && $signed(est_code_o[j]) >= -tap_abs_sum)
        ) else $error("channel_filter: lane %0d code outside tap range", j);
    end

endmodule : channel_filter

// ==== ffe_slicer/ffe_slicer.sv ====
module ffe_slicer
    import dsp_const_pkg::*, dsp_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  adc_word_t            adc_i,
    input  dsp_cfg_t             cfg_i,
    output est_arr_t             est_o,
    output logic [num_lanes-1:0] sliced_o
);

    localparam int sum_bits = code_bits + weight_bits + $clog2(ffe_taps);

    code_arr_t                  prev_codes;
    code_t                      ext_codes [2*num_lanes];
    logic signed [sum_bits-1:0] lane_sum [num_lanes];
    est_arr_t                   est_c;
    logic [num_lanes-1:0]       slice_c;

    // Taps may only reach back one word
    if (ffe_taps > num_lanes + 1) begin : g_taps_chk
        $error("ffe_slicer: ffe_taps exceeds one word of history");
    end

    // Previous word first, so sample j of this word sits at j + num_lanes
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            ext_codes[i]           = prev_codes[i];
            ext_codes[i+num_lanes] = adc_i.codes[i];
        end
    end

    always_comb begin
        for (int j = 0; j < num_lanes; j++) begin
            lane_sum[j] = '0;
            for (int k = 0; k < ffe_taps; k++) begin
                lane_sum[j] = lane_sum[j]
                            + $signed(cfg_i.weights[k]) * $signed(ext_codes[j+num_lanes-k]);
            end
        end
    end

    // Scale down, keep the low bits, then slice
    always_comb begin
        logic signed [sum_bits-1:0] shifted;

        shifted = '0;
        for (int j = 0; j < num_lanes; j++) begin
            shifted    = lane_sum[j] >>> cfg_i.ffe_shift;
            est_c[j]   = shifted[est_bits_w-1:0];
            slice_c[j] = ($signed(est_c[j]) >= $signed(cfg_i.thresh));
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            prev_codes <= '0;
            est_o      <= '0;
            sliced_o   <= '0;
        end else begin
            prev_codes <= adc_i.codes;
            est_o      <= est_c;
            sliced_o   <= slice_c;
        end
    end

endmodule : ffe_slicer

// ==== verilog/lane_delay.sv ====
module lane_delay #(
    parameter int width = 1,
    parameter int depth = 1
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic [width-1:0] d_i,
    output logic [width-1:0] q_o
);

    logic [depth-1:0][width-1:0] chain;

    if (depth < 1) begin : g_depth_chk
        $error("lane_delay: depth must be at least 1");
    end

    // Stage 0 takes the input, the last stage drives the output
    always_ff @(posedge clk) begin
        if (rst_i) begin
            chain <= '0;
        end else begin
            chain[0] <= d_i;
            for (int i = 1; i < depth; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign q_o = chain[depth-1];

endmodule : lane_delay

// ==== common/dsp_cfg_pkg.sv ====
package dsp_cfg_pkg;

    import dsp_const_pkg::*;

    // Quasi-static settings, only changed between tests
    typedef struct packed {
        weight_t [ffe_taps-1:0]  weights;
        logic [shift_bits-1:0]   ffe_shift;
        est_t                    thresh;
        tap_t [chan_taps-1:0]    taps;
    } dsp_cfg_t;

    // One word of parallel ADC samples
    typedef struct packed {
        code_arr_t codes;
    } adc_word_t;

    // Everything below belongs to the same input word
    typedef struct packed {
        est_arr_t             est_bits;
        logic [num_lanes-1:0] sliced;
        ecode_arr_t           est_codes;
        err_arr_t             errors;
        logic [num_lanes-1:0] flags;
    } dsp_out_t;

endpackage : dsp_cfg_pkg

// ==== common/dsp_const_pkg.sv ====
package dsp_const_pkg;

    // Samples per word, lane 0 is the earliest
    localparam int num_lanes = 4;

    // Filter lengths
    localparam int ffe_taps  = 3;
    localparam int chan_taps = 3;

    localparam int code_bits     = 8;
    localparam int weight_bits   = 8;
    localparam int shift_bits    = 4;
    localparam int est_bits_w    = 10;
    localparam int tap_bits      = 8;
    localparam int est_code_bits = 10;
    localparam int err_bits      = 11;

    // Scalar element types, all signed
    typedef logic signed [code_bits-1:0]     code_t;
    typedef logic signed [weight_bits-1:0]   weight_t;
    typedef logic signed [est_bits_w-1:0]    est_t;
    typedef logic signed [tap_bits-1:0]      tap_t;
    typedef logic signed [est_code_bits-1:0] ecode_t;
    typedef logic signed [err_bits-1:0]      err_t;

    // One element per lane
    typedef code_t  [num_lanes-1:0] code_arr_t;
    typedef est_t   [num_lanes-1:0] est_arr_t;
    typedef ecode_t [num_lanes-1:0] ecode_arr_t;
    typedef err_t   [num_lanes-1:0] err_arr_t;

endpackage : dsp_const_pkg
